// ==== Bender.yml ====
package:
  name: temporal_pe

sources:
  - include_dirs:
      - .
    files:
      - pe_stream_pkg.sv
      - pe_insn_pkg.sv
      - pe_ifc.sv
      - pe_insn_mem.sv
      - pe_operand_buffer.sv
      - pe_fire_unit.sv
      - pe_error_reg.sv
      - temporal_pe.sv
  - target: test
    include_dirs:
      - .
    files:
      - temporal_pe_props.sv
      - tb_temporal_pe.sv

// ==== pe_error_reg.sv ====
// Temporal PE error register
// Priority-encodes the error flags and holds the first code until reset
`include "temporal_pe_defines.svh"

module pe_error_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    dup_tag,
  input  logic                    no_match,
  output logic                    error_valid,
  output pe_insn_pkg::err_code_t  error_code
);

  pe_insn_pkg::err_code_t code_next;

  // Configuration fault ahead of runtime fault
  always_comb begin
    if (dup_tag) begin
      code_next = `PE_ERR_DUP_TAG;
    end else if (no_match) begin
      code_next = `PE_ERR_NO_MATCH;
    end else begin
      code_next = `PE_ERR_NONE;
    end
  end

  // First nonzero code sticks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= `PE_ERR_NONE;
    end else if (!error_valid && (code_next != `PE_ERR_NONE)) begin
      error_valid <= 1'b1;
      error_code  <= code_next;
    end
  end

endmodule

// ==== pe_fire_unit.sv ====
// Temporal PE fire unit
// Picks the lowest ready slot, runs add or xor and commits on output take
`include "temporal_pe_defines.svh"

module pe_fire_unit (
  insn_table_if.user                   tbl,
  op_state_if.disp                     ops,
  // Result stream
  input  logic                         out_ready,
  output logic                         out_valid,
  output pe_stream_pkg::payload_t      out_data
);

  logic                  found;
  pe_stream_pkg::slot_t  sel;
  pe_stream_pkg::value_t opa;
  pe_stream_pkg::value_t opb;
  pe_stream_pkg::value_t result;

  // ----------------------------------------
  // Slot select
  // ----------------------------------------
  // First slot with a live instruction and every operand present
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      if (!found && tbl.valid[i] && (&ops.op_valid[i])) begin
        found = 1'b1;
        sel   = pe_stream_pkg::slot_t'(i);
      end
    end
  end

  // ----------------------------------------
  // Function unit, single cycle
  // ----------------------------------------
  assign opa = ops.op_value[sel][0];
  assign opb = ops.op_value[sel][1];

  always_comb begin
    case (tbl.fu_sel[sel])
      pe_insn_pkg::FU_XOR: result = opa ^ opb;
      default:             result = opa + opb;
    endcase
  end

  // ----------------------------------------
  // Output and commit
  // ----------------------------------------
  // Held while out_ready is low since the entries stay full
  assign out_valid      = found;
  assign out_data.tag   = tbl.res_tag[sel];
  assign out_data.value = result;

  // Commit only when the result is taken
  assign ops.fire      = found && out_ready;
  assign ops.fire_slot = sel;

endmodule

// ==== pe_ifc.sv ====
// Temporal PE internal interfaces
// Decoded instruction table and per-slot operand state with fire control
`include "temporal_pe_defines.svh"

// ----------------------------------------
// Decoded instruction table
// ----------------------------------------
interface insn_table_if;
  logic [`PE_NUM_INSNS-1:0]                        valid;
  pe_stream_pkg::tag_t [`PE_NUM_INSNS-1:0]         match_tag;
  pe_insn_pkg::fu_sel_e [`PE_NUM_INSNS-1:0]        fu_sel;
  pe_stream_pkg::tag_t [`PE_NUM_INSNS-1:0]         res_tag;

  // Memory side publishes the fields
  modport mem (output valid, match_tag, fu_sel, res_tag);

  // Buffer and fire unit only look
  modport user (input valid, match_tag, fu_sel, res_tag);
endinterface

// ----------------------------------------
// Operand state and fire handshake
// ----------------------------------------
interface op_state_if;
  // Per slot, per input
  logic [`PE_NUM_INSNS-1:0][`PE_NUM_INPUTS-1:0]                        op_valid;
  pe_stream_pkg::value_t [`PE_NUM_INSNS-1:0][`PE_NUM_INPUTS-1:0]       op_value;

  // Commit of one slot, result taken by the output
  logic                 fire;
  pe_stream_pkg::slot_t fire_slot;

  // Operand buffer owns the entries and follows fire
  modport buffer (output op_valid, op_value, input fire, fire_slot);

  // Dispatcher picks a slot and commits it
  modport disp (input op_valid, op_value, output fire, fire_slot);
endinterface

// ==== pe_insn_mem.sv ====
// Temporal PE instruction memory
// APB-written slots, decoded onto the table, with duplicate-tag detection
`include "temporal_pe_defines.svh"

module pe_insn_mem (
  input  logic                     clk,
  input  logic                     rst_n,
  // APB slave
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  pe_insn_pkg::apb_addr_t   paddr,
  input  logic [31:0]              pwdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [31:0]              prdata,
  // Decoded table
  insn_table_if.mem                tbl,
  output logic                     dup_tag
);

  localparam int INSN_W = $bits(pe_insn_pkg::insn_word_t);

  pe_insn_pkg::insn_word_t mem [`PE_NUM_INSNS];

  logic                 access;
  logic                 in_range;
  pe_stream_pkg::slot_t addr_slot;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  assign access    = psel && penable;
  assign addr_slot = paddr[`PE_SLOT_W+1:2];

  // Word aligned and nothing set above the slot index
  assign in_range = (paddr[1:0] == 2'b00) &&
                    (paddr[`PE_APB_ADDR_W-1:`PE_SLOT_W+2] == '0);

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !in_range;

  // Stored word in the low bits, rest reads as zero
  assign prdata = in_range ? {{(32-INSN_W){1'b0}}, mem[addr_slot]} : '0;

  // ----------------------------------------
  // Slot storage
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PE_NUM_INSNS; i++) begin
        mem[i] <= '0;
      end
    end else if (access && pwrite && in_range) begin
      // New word visible the cycle after the access phase
      mem[addr_slot] <= pe_insn_pkg::insn_word_t'(pwdata[INSN_W-1:0]);
    end
  end

  // Field decode for the rest of the PE
  always_comb begin
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      tbl.valid[i]     = mem[i].valid;
      tbl.match_tag[i] = mem[i].match_tag;
      tbl.fu_sel[i]    = mem[i].fu_sel;
      tbl.res_tag[i]   = mem[i].res_tag;
    end
  end

  // ----------------------------------------
  // Duplicate tag check
  // ----------------------------------------
  // Every pair of valid slots, each pair once
  always_comb begin
    dup_tag = 1'b0;
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      for (int k = i + 1; k < `PE_NUM_INSNS; k++) begin
        if (mem[i].valid && mem[k].valid && (mem[i].match_tag == mem[k].match_tag)) begin
          dup_tag = 1'b1;
        end
      end
    end
  end

endmodule

// ==== pe_insn_pkg.sv ====
// Temporal PE instruction and configuration types
// Stored instruction word, function select and APB side types
`include "temporal_pe_defines.svh"

package pe_insn_pkg;

  // ----------------------------------------
  // Function unit
  // ----------------------------------------
  typedef enum logic {
    FU_ADD = 1'b0,
    FU_XOR = 1'b1
  } fu_sel_e;

  // ----------------------------------------
  // Instruction word, 10 bits
  // ----------------------------------------
  // Valid in bit 0, result tag in the top four bits
  typedef struct packed {
    pe_stream_pkg::tag_t res_tag;
    fu_sel_e             fu_sel;
    pe_stream_pkg::tag_t match_tag;
    logic                valid;
  } insn_word_t;

  // Byte address on the configuration bus
  typedef logic [`PE_APB_ADDR_W-1:0] apb_addr_t;

  // Latched error code
  typedef logic [`PE_ERR_W-1:0] err_code_t;

endpackage

// ==== pe_operand_buffer.sv ====
// Temporal PE operand buffer
// Tag-matches each input to a slot and holds one operand per slot and input
`include "temporal_pe_defines.svh"

module pe_operand_buffer (
  input  logic                                            clk,
  input  logic                                            rst_n,
  // Operand streams
  input  logic [`PE_NUM_INPUTS-1:0]                       in_valid,
  input  pe_stream_pkg::payload_t [`PE_NUM_INPUTS-1:0]    in_data,
  output logic [`PE_NUM_INPUTS-1:0]                       in_ready,
  // Table lookup and operand state
  insn_table_if.user                                      tbl,
  op_state_if.buffer                                      ops,
  output logic                                            no_match
);

  // Entry state, per slot and input
  logic [`PE_NUM_INSNS-1:0][`PE_NUM_INPUTS-1:0]                  op_valid_q;
  pe_stream_pkg::value_t [`PE_NUM_INSNS-1:0][`PE_NUM_INPUTS-1:0] op_value_q;

  // Lookup result per input
  logic [`PE_NUM_INPUTS-1:0]                       hit;
  pe_stream_pkg::slot_t [`PE_NUM_INPUTS-1:0]       hit_slot;

  // ----------------------------------------
  // Tag match and accept
  // ----------------------------------------
  always_comb begin
    no_match = 1'b0;
    for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
      hit[j]      = 1'b0;
      hit_slot[j] = '0;
      // Walk down so the lowest matching slot wins
      for (int i = `PE_NUM_INSNS - 1; i >= 0; i--) begin
        if (tbl.valid[i] && (tbl.match_tag[i] == in_data[j].tag)) begin
          hit[j]      = 1'b1;
          hit_slot[j] = pe_stream_pkg::slot_t'(i);
        end
      end
      // Ready only while the target entry is empty
      in_ready[j] = in_valid[j] && hit[j] && !op_valid_q[hit_slot[j]][j];
      // Offered operand with nowhere to go
      no_match = no_match | (in_valid[j] && !hit[j]);
    end
  end

  // ----------------------------------------
  // Entry valid bits
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid_q <= '0;
    end else begin
      // Fired slot frees both entries
      if (ops.fire) begin
        op_valid_q[ops.fire_slot] <= '0;
      end
      // A cleared entry had in_ready low, so set and clear never collide
      for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
        if (in_ready[j]) begin
          op_valid_q[hit_slot[j]][j] <= 1'b1;
        end
      end
    end
  end

  // Operand payload, qualified by the valid bits
  always_ff @(posedge clk) begin
    for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
      if (in_ready[j]) begin
        op_value_q[hit_slot[j]][j] <= in_data[j].value;
      end
    end
  end

  // Published to the fire unit
  assign ops.op_valid = op_valid_q;
  assign ops.op_value = op_value_q;

endmodule

// ==== pe_stream_pkg.sv ====
// Temporal PE stream types
// Tags, values and the tagged payload carried on every stream port
`include "temporal_pe_defines.svh"

package pe_stream_pkg;

  // Dispatch tag
  typedef logic [`PE_TAG_W-1:0] tag_t;

  // Operand or result value
  typedef logic [`PE_DATA_W-1:0] value_t;

  // Tag sits in the upper bits
  typedef struct packed {
    tag_t   tag;
    value_t value;
  } payload_t;

  // Index of an instruction slot
  typedef logic [`PE_SLOT_W-1:0] slot_t;

endpackage

// ==== tb_temporal_pe.sv ====
// Testbench for the temporal PE
// APB setup, random operand streams against a slot model, error code checks
`include "temporal_pe_defines.svh"

module tb_temporal_pe;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_RAND = 300;
  localparam int N_BP   = 200;
  // Up to two cycles per pair at full rate and six under back-pressure plus setup
  localparam int CYCLE_LIMIT = 2 * (2 * N_RAND + 6 * N_BP + 200);

  logic                                         clk;
  logic                                         rst_n;
  logic                                         psel;
  logic                                         penable;
  logic                                         pwrite;
  pe_insn_pkg::apb_addr_t                       paddr;
  logic [31:0]                                  pwdata;
  logic                                         pready;
  logic                                         pslverr;
  logic [31:0]                                  prdata;
  logic [`PE_NUM_INPUTS-1:0]                    in_valid;
  logic [`PE_NUM_INPUTS-1:0]                    in_ready;
  pe_stream_pkg::payload_t [`PE_NUM_INPUTS-1:0] in_data;
  logic                                         out_valid;
  logic                                         out_ready;
  pe_stream_pkg::payload_t                      out_data;
  logic                                         error_valid;
  pe_insn_pkg::err_code_t                       error_code;

  integer seed;
  int     cycles;

  // ----------------------------------------
  // Slot model
  // ----------------------------------------
  logic [`PE_NUM_INSNS-1:0]   m_valid;
  pe_stream_pkg::tag_t        m_tag [`PE_NUM_INSNS];
  logic                       m_xor [`PE_NUM_INSNS];
  pe_stream_pkg::tag_t        m_res [`PE_NUM_INSNS];
  logic [`PE_NUM_INPUTS-1:0]  m_full [`PE_NUM_INSNS];
  pe_stream_pkg::value_t      m_val [`PE_NUM_INSNS][`PE_NUM_INPUTS];

  // Distinct match tags and a slot tag sequence shared by both inputs
  pe_stream_pkg::tag_t slot_tags [`PE_NUM_INSNS] = '{4'h3, 4'h7, 4'hA, 4'hC};
  pe_stream_pkg::tag_t tag_seq [N_RAND];

  temporal_pe temporal_pe_i (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic expect_equal(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (actual !== expected) begin
      $display("error: %s expected 0x%0h got 0x%0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Lowest valid slot with the tag or -1 when none
  function automatic int model_slot(input pe_stream_pkg::tag_t tag);
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      if (m_valid[i] && m_tag[i] == tag) return i;
    end
    return -1;
  endfunction

  function automatic int lowest_full_slot();
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      if (m_valid[i] && (&m_full[i])) return i;
    end
    return -1;
  endfunction

  task automatic reset_dut();
    @(posedge clk);
    #1;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    in_valid = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    m_valid = '0;
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      m_full[i] = '0;
    end
  endtask

  // ----------------------------------------
  // APB master
  // ----------------------------------------
  task automatic apb_access(input logic write, input pe_insn_pkg::apb_addr_t addr,
                            input logic [31:0] data, input logic exp_err,
                            output logic [31:0] rdata);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    expect_equal("pready", 1'b1, pready);
    expect_equal("pslverr", exp_err, pslverr);
    rdata = prdata;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Stored word in bits 9:0 with zero upper bits
  task automatic read_back(input int slot);
    logic [31:0] rdata;
    apb_access(1'b0, pe_insn_pkg::apb_addr_t'(slot * 4), '0, 1'b0, rdata);
    expect_equal($sformatf("prdata[slot %0d]", slot),
                 {22'b0, m_res[slot], m_xor[slot], m_tag[slot], m_valid[slot]}, rdata);
  endtask

  task automatic configure_slot(input int slot, input logic vld, input pe_stream_pkg::tag_t tag,
                                input logic use_xor, input pe_stream_pkg::tag_t res);
    logic [31:0] word;
    logic [31:0] rdata;
    // Junk above the instruction field
    word      = $random(seed);
    word[9:0] = {res, use_xor, tag, vld};
    apb_access(1'b1, pe_insn_pkg::apb_addr_t'(slot * 4), word, 1'b0, rdata);
    m_valid[slot] = vld;
    m_tag[slot]   = tag;
    m_xor[slot]   = use_xor;
    m_res[slot]   = res;
    read_back(slot);
  endtask

  // ----------------------------------------
  // Operand streams against the model
  // ----------------------------------------
  task automatic run_streams(input int n_pairs, input bit random_gaps);
    int                    sent [`PE_NUM_INPUTS];
    bit                    accepted [`PE_NUM_INPUTS];
    int                    taken;
    int                    exp_slot;
    int                    s;
    logic                  exp_ready;
    pe_stream_pkg::value_t res;
    for (int k = 0; k < n_pairs; k++) begin
      tag_seq[k] = m_tag[$unsigned($random(seed)) % `PE_NUM_INSNS];
    end
    for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
      sent[j]     = 0;
      accepted[j] = 1'b0;
    end
    taken = 0;
    while (taken < n_pairs) begin
      @(posedge clk);
      #1;
      out_ready = random_gaps ? (($random(seed) & 1) != 0) : 1'b1;
      for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
        // Taken operand leaves and the next one may follow at once
        if (accepted[j]) begin
          in_valid[j] = 1'b0;
          sent[j]++;
          accepted[j] = 1'b0;
        end
        if (!in_valid[j] && sent[j] < n_pairs && (!random_gaps || ($random(seed) & 1) != 0)) begin
          in_valid[j]      = 1'b1;
          in_data[j].tag   = tag_seq[sent[j]];
          in_data[j].value = $random(seed);
        end
      end
      @(negedge clk);
      // Expected result from the lowest full slot
      exp_slot = lowest_full_slot();
      expect_equal("out_valid", exp_slot >= 0, out_valid);
      if (exp_slot >= 0) begin
        res = m_xor[exp_slot] ? (m_val[exp_slot][0] ^ m_val[exp_slot][1]) :
                                (m_val[exp_slot][0] + m_val[exp_slot][1]);
        expect_equal("out_data.tag", m_res[exp_slot], out_data.tag);
        expect_equal("out_data.value", res, out_data.value);
      end
      for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
        s         = model_slot(in_data[j].tag);
        exp_ready = 1'b0;
        if (in_valid[j] && s >= 0) exp_ready = !m_full[s][j];
        expect_equal($sformatf("in_ready[%0d]", j), exp_ready, in_ready[j]);
      end
      // Fire clears at the coming edge and accepts then fill
      if (exp_slot >= 0 && out_ready) begin
        m_full[exp_slot] = '0;
        taken++;
      end
      for (int j = 0; j < `PE_NUM_INPUTS; j++) begin
        if (in_valid[j] && in_ready[j]) begin
          s              = model_slot(in_data[j].tag);
          m_full[s][j]   = 1'b1;
          m_val[s][j]    = in_data[j].value;
          accepted[j]    = 1'b1;
        end
      end
    end
    @(posedge clk);
    #1;
    in_valid  = '0;
    out_ready = 1'b1;
    @(negedge clk);
    // Nothing left over and nothing replayed
    expect_equal("out_valid", 1'b0, out_valid);
    expect_equal("error_valid", 1'b0, error_valid);
  endtask

  // Offer an operand with a tag no slot holds
  task automatic offer_unmatched(input pe_stream_pkg::tag_t tag);
    @(posedge clk);
    #1;
    in_valid[0]      = 1'b1;
    in_data[0].tag   = tag;
    in_data[0].value = $random(seed);
    repeat (2) begin
      @(negedge clk);
      expect_equal("in_ready[0]", 1'b0, in_ready[0]);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] rdata;
    seed      = 97938;
    cycles    = 0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    in_valid  = '0;
    in_data   = '0;
    out_ready = 1'b1;
    reset_dut();

    // Configure and read back before a rejected access
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      configure_slot(i, 1'b1, slot_tags[i], ($random(seed) & 1) != 0,
                     pe_stream_pkg::tag_t'($random(seed)));
    end
    apb_access(1'b1, pe_insn_pkg::apb_addr_t'(16), 32'hFFFF_FFFF, 1'b1, rdata);
    for (int i = 0; i < `PE_NUM_INSNS; i++) begin
      read_back(i);
    end

    // Full throughput followed by random gaps and back-pressure
    run_streams(N_RAND, 1'b0);
    run_streams(N_BP, 1'b1);

    // Unmatched tag
    offer_unmatched(4'h0);
    expect_equal("error_valid", 1'b1, error_valid);
    expect_equal("error_code", `PE_ERR_NO_MATCH, error_code);

    // Duplicate tag after a fresh reset stays latched through later faults
    reset_dut();
    configure_slot(0, 1'b1, 4'h5, 1'b0, 4'h1);
    configure_slot(1, 1'b1, 4'h5, 1'b1, 4'h2);
    @(negedge clk);
    expect_equal("error_valid", 1'b1, error_valid);
    expect_equal("error_code", `PE_ERR_DUP_TAG, error_code);
    // Resolving the duplicate leaves the latched code in place
    configure_slot(1, 1'b1, 4'h6, 1'b1, 4'h2);
    offer_unmatched(4'h9);
    expect_equal("error_valid", 1'b1, error_valid);
    expect_equal("error_code", `PE_ERR_DUP_TAG, error_code);
    @(posedge clk);
    #1 in_valid = '0;

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== temporal_pe.sv ====
// Temporal processing element, tag-dispatched
// Instruction memory, operand buffer, fire unit and error register
`include "temporal_pe_defines.svh"

module temporal_pe (
  input  logic                                          clk,
  input  logic                                          rst_n,
  // APB configuration slave
  input  logic                                          psel,
  input  logic                                          penable,
  input  logic                                          pwrite,
  input  pe_insn_pkg::apb_addr_t                        paddr,
  input  logic [31:0]                                   pwdata,
  output logic                                          pready,
  output logic                                          pslverr,
  output logic [31:0]                                   prdata,
  // Operand streams
  input  logic [`PE_NUM_INPUTS-1:0]                     in_valid,
  output logic [`PE_NUM_INPUTS-1:0]                     in_ready,
  input  pe_stream_pkg::payload_t [`PE_NUM_INPUTS-1:0]  in_data,
  // Result stream
  output logic                                          out_valid,
  input  logic                                          out_ready,
  output pe_stream_pkg::payload_t                       out_data,
  // Sticky error
  output logic                                          error_valid,
  output pe_insn_pkg::err_code_t                        error_code
);

  logic dup_tag;
  logic no_match;

  insn_table_if insn_tbl ();
  op_state_if   op_state ();

  // ----------------------------------------
  // Configuration
  // ----------------------------------------
  pe_insn_mem insn_mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .pslverr (pslverr),
    .prdata  (prdata),
    .tbl     (insn_tbl.mem),
    .dup_tag (dup_tag)
  );

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  pe_operand_buffer operand_buffer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_ready (in_ready),
    .tbl      (insn_tbl.user),
    .ops      (op_state.buffer),
    .no_match (no_match)
  );

  pe_fire_unit fire_unit_i (
    .tbl       (insn_tbl.user),
    .ops       (op_state.disp),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  // Error latch
  pe_error_reg error_reg_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .dup_tag     (dup_tag),
    .no_match    (no_match),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

endmodule

// ==== temporal_pe_defines.svh ====
// Temporal PE shared parameters
// Stream widths, slot count, APB address bits and error codes
`ifndef TEMPORAL_PE_DEFINES_SVH
`define TEMPORAL_PE_DEFINES_SVH

// ----------------------------------------
// Stream payload
// ----------------------------------------
`define PE_DATA_W       32
`define PE_TAG_W        4

// Instruction slots and operand inputs
`define PE_NUM_INSNS    4
`define PE_NUM_INPUTS   2
`define PE_SLOT_W       2

// Byte address, one word per slot and one bit above the slot range
`define PE_APB_ADDR_W   5

// ----------------------------------------
// Sticky error codes
// ----------------------------------------
`define PE_ERR_W        16
`define PE_ERR_NONE     16'd0
`define PE_ERR_DUP_TAG  16'd1
`define PE_ERR_NO_MATCH 16'd2

`endif

// ==== temporal_pe_props.sv ====
// Temporal PE handshake properties
// Bound into the top level, checked at every rising clock edge
`include "temporal_pe_defines.svh"

module temporal_pe_props (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      psel,
  input logic                      penable,
  input logic                      pslverr,
  input logic [`PE_NUM_INPUTS-1:0] in_valid,
  input logic [`PE_NUM_INPUTS-1:0] in_ready,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic                      error_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Result stays offered until taken
  out_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid dropped before out_ready");

  // No ready without an offered operand
  in_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (in_ready & ~in_valid) == '0)
    else $error("in_ready high without in_valid");

  // Sticky error
  error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(error_valid))
    else $error("error_valid fell without reset");

  // Slave error only in the access phase
  pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> psel && penable)
    else $error("pslverr outside an access phase");

endmodule

bind temporal_pe temporal_pe_props props_i (.*);

// ==== vlog.f ====
+incdir+.
pe_stream_pkg.sv
pe_insn_pkg.sv
pe_ifc.sv
pe_insn_mem.sv
pe_operand_buffer.sv
pe_fire_unit.sv
pe_error_reg.sv
temporal_pe.sv
temporal_pe_props.sv
tb_temporal_pe.sv
